//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ///////////////////////////////////////////////////////////////////////
    // geometry
    ///////////////////////////////////////////////////////////////////////
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 256;
    localparam int WORDS_PER_LINE = 4;
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 4;

    ///////////////////////////////////////////////////////////////////////
    // address fields and data
    ///////////////////////////////////////////////////////////////////////
    typedef logic [TAG_W-1:0]                   tag_t;
    typedef logic [INDEX_W-1:0]                 index_t;
    // upper two bits pick the word
    typedef logic [OFFSET_W-1:0]                offset_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]  word_sel_t;
    typedef logic [31:0]                        word_t;
    typedef logic [3:0]                         strb_t;
    // word 0 sits in the low bits
    typedef logic [WORDS_PER_LINE*32-1:0]       line_t;
    typedef logic [31:0]                        addr_t;

    // one cpu request with op high for store
    typedef struct packed {
        logic    op;
        tag_t    tag;
        index_t  index;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } cpu_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        MISS,
        REFILL
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- design/store_merge.sv
`timescale 1ns/1ns
`default_nettype none

module store_merge (
    input  logic                 hit_store,
    input  logic                 refill,
    input  logic                 way,
    input  dcache_pkg::cpu_req_t cur_req,
    input  dcache_pkg::line_t    ret_data,
    input  dcache_pkg::line_t    cur_line,
    output logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::WORDS_PER_LINE-1:0] bank_we,
    output dcache_pkg::line_t    wline
);
    import dcache_pkg::*;

    localparam int WW = $bits(word_t);

    word_sel_t wsel;
    line_t     base;
    word_t     old_word;
    word_t     new_word;

    assign wsel = cur_req.offset[OFFSET_W-1 -: $bits(word_sel_t)];

    always_comb begin
        // refill merges into memory data, hit store into the cached line
        base     = refill ? ret_data : cur_line;
        old_word = base[wsel*WW +: WW];
        for (int i = 0; i < $bits(strb_t); i++) begin
            new_word[i*8 +: 8] = cur_req.wstrb[i] ? cur_req.wdata[i*8 +: 8]
                                                  : old_word[i*8 +: 8];
        end
        wline = base;
        if (cur_req.op) begin
            wline[wsel*WW +: WW] = new_word;
        end

        bank_we = '0;
        if (refill) begin
            bank_we[way] = '1;
        end else if (hit_store) begin
            bank_we[way][wsel] = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/data_store.sv
`timescale 1ns/1ns
`default_nettype none

module data_store (
    input  logic               clk,
    input  dcache_pkg::index_t set_index,
    input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::WORDS_PER_LINE-1:0] bank_we,
    input  dcache_pkg::line_t  wline,
    output dcache_pkg::line_t  way_line [dcache_pkg::NUM_WAYS]
);
    import dcache_pkg::*;

    localparam int WW = $bits(word_t);

    // one word bank per way and word
    word_t bank_mem [NUM_WAYS][WORDS_PER_LINE][NUM_SETS];

    ///////////////////////////////////////////////////////////////////////
    // read-first banks with registered output
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int b = 0; b < WORDS_PER_LINE; b++) begin
                if (bank_we[w][b]) begin
                    bank_mem[w][b][set_index] <= wline[b*WW +: WW];
                end
                way_line[w][b*WW +: WW] <= bank_mem[w][b][set_index];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/tag_store.sv
`timescale 1ns/1ns
`default_nettype none

module tag_store (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_pkg::index_t     set_index,
    input  logic                   tag_we,
    input  logic                   fill_way,
    input  dcache_pkg::tag_t       fill_tag,
    input  logic                   dirty_set,
    input  logic                   dirty_clr,
    input  logic                   hit_way,
    output dcache_pkg::tag_t       way_tag [dcache_pkg::NUM_WAYS],
    output logic [dcache_pkg::NUM_WAYS-1:0] way_valid,
    output logic [dcache_pkg::NUM_WAYS-1:0] way_dirty,
    output logic                   victim_bit
);
    import dcache_pkg::*;

    tag_t tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;
    logic [NUM_SETS-1:0]               victim_q;

    // status bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            victim_q <= '0;
        end else begin
            if (tag_we) begin
                valid_q[set_index][fill_way] <= 1'b1;
                victim_q[set_index]          <= ~victim_q[set_index];
            end
            if (dirty_set) begin
                dirty_q[set_index][hit_way] <= 1'b1;
            end else if (dirty_clr) begin
                dirty_q[set_index][hit_way] <= 1'b0;
            end
        end
    end

    // tag array and registered read of the whole set
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[fill_way][set_index] <= fill_tag;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_tag[w] <= tag_mem[w][set_index];
        end
        way_valid  <= valid_q[set_index];
        way_dirty  <= dirty_q[set_index];
        victim_bit <= victim_q[set_index];
    end

endmodule

`default_nettype wire

//--- design/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output logic                 rd_req,
    output dcache_pkg::addr_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  dcache_pkg::line_t    ret_data,
    output logic                 wr_req,
    output dcache_pkg::addr_t    wr_addr,
    output dcache_pkg::line_t    wr_data,
    input  logic                 wr_rdy,
    output dcache_pkg::index_t   set_index,
    input  dcache_pkg::tag_t     way_tag [dcache_pkg::NUM_WAYS],
    input  logic [dcache_pkg::NUM_WAYS-1:0] way_valid,
    input  logic [dcache_pkg::NUM_WAYS-1:0] way_dirty,
    input  logic                 victim_bit,
    input  dcache_pkg::line_t    way_line [dcache_pkg::NUM_WAYS],
    output logic                 tag_we,
    output logic                 fill_way,
    output dcache_pkg::tag_t     fill_tag,
    output logic                 dirty_set,
    output logic                 dirty_clr,
    output logic                 hit_store,
    output logic                 refill,
    output logic                 hit_way,
    output dcache_pkg::cpu_req_t cur_req
);
    import dcache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic [NUM_WAYS-1:0] hit_vec;
    logic      hit;
    logic      hit_idx;
    logic      pick_way;
    logic      victim_q;
    word_sel_t wsel;
    line_t     src_line;

    ///////////////////////////////////////////////////////////////////////
    // request latch and state
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (req_valid && addr_ok) begin
            cur_req <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            victim_q <= 1'b0;
        end else begin
            state <= state_nxt;
            // victim chosen in lookup and kept until the refill ends
            if (state == LOOKUP && !hit) begin
                victim_q <= pick_way;
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // hit and victim choice
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = way_valid[w] && (way_tag[w] == cur_req.tag);
        end
    end

    assign hit     = |hit_vec;
    assign hit_idx = hit_vec[1];

    // free way first, then the per-set victim bit
    always_comb begin
        if (!way_valid[0]) begin
            pick_way = 1'b0;
        end else if (!way_valid[1]) begin
            pick_way = 1'b1;
        end else begin
            pick_way = victim_bit;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_nxt = IDLE;
                end else if (way_valid[pick_way] && way_dirty[pick_way]) begin
                    state_nxt = WRITEBACK;
                end else begin
                    state_nxt = MISS;
                end
            end
            WRITEBACK: begin
                if (wr_rdy) begin
                    state_nxt = MISS;
                end
            end
            MISS: begin
                if (rd_rdy) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // port outputs and array commands
    ///////////////////////////////////////////////////////////////////////
    assign addr_ok   = (state == IDLE);
    assign data_ok   = (state == LOOKUP && hit) || (state == REFILL && ret_valid);
    assign set_index = (state == IDLE) ? req.index : cur_req.index;

    assign rd_req  = (state == MISS);
    assign rd_addr = {cur_req.tag, cur_req.index, {OFFSET_W{1'b0}}};
    assign wr_req  = (state == WRITEBACK);
    assign wr_addr = {way_tag[victim_q], cur_req.index, {OFFSET_W{1'b0}}};
    assign wr_data = way_line[victim_q];

    assign hit_store = (state == LOOKUP) && hit && cur_req.op;
    assign refill    = (state == REFILL) && ret_valid;
    assign tag_we    = refill;
    assign fill_way  = victim_q;
    assign fill_tag  = cur_req.tag;
    assign dirty_set = hit_store || (refill && cur_req.op);
    assign dirty_clr = refill && !cur_req.op;
    // way written this cycle is the hit way or the fill way
    assign hit_way   = (state == REFILL) ? victim_q : hit_idx;

    // load word from the hit line or straight from memory
    assign wsel     = cur_req.offset[OFFSET_W-1 -: $bits(word_sel_t)];
    assign src_line = (state == REFILL) ? ret_data : way_line[hit_idx];
    assign rdata    = src_line[wsel*$bits(word_t) +: $bits(word_t)];

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output logic                 rd_req,
    output dcache_pkg::addr_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  dcache_pkg::line_t    ret_data,
    output logic                 wr_req,
    output dcache_pkg::addr_t    wr_addr,
    output dcache_pkg::line_t    wr_data,
    input  logic                 wr_rdy
);
    import dcache_pkg::*;

    index_t   set_index;
    tag_t     way_tag [NUM_WAYS];
    logic [NUM_WAYS-1:0] way_valid;
    logic [NUM_WAYS-1:0] way_dirty;
    logic     victim_bit;
    line_t    way_line [NUM_WAYS];
    logic     tag_we;
    logic     fill_way;
    tag_t     fill_tag;
    logic     dirty_set;
    logic     dirty_clr;
    logic     hit_store;
    logic     refill;
    logic     hit_way;
    cpu_req_t cur_req;
    logic [NUM_WAYS-1:0][WORDS_PER_LINE-1:0] bank_we;
    line_t    wline;
    line_t    sel_line;

    // old contents of the way being written for partial stores
    assign sel_line = way_line[hit_way];

    cache_ctrl cache_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy),
        .set_index  (set_index),
        .way_tag    (way_tag),
        .way_valid  (way_valid),
        .way_dirty  (way_dirty),
        .victim_bit (victim_bit),
        .way_line   (way_line),
        .tag_we     (tag_we),
        .fill_way   (fill_way),
        .fill_tag   (fill_tag),
        .dirty_set  (dirty_set),
        .dirty_clr  (dirty_clr),
        .hit_store  (hit_store),
        .refill     (refill),
        .hit_way    (hit_way),
        .cur_req    (cur_req)
    );

    tag_store tag_store_i (
        .clk        (clk),
        .reset      (reset),
        .set_index  (set_index),
        .tag_we     (tag_we),
        .fill_way   (fill_way),
        .fill_tag   (fill_tag),
        .dirty_set  (dirty_set),
        .dirty_clr  (dirty_clr),
        .hit_way    (hit_way),
        .way_tag    (way_tag),
        .way_valid  (way_valid),
        .way_dirty  (way_dirty),
        .victim_bit (victim_bit)
    );

    data_store data_store_i (
        .clk       (clk),
        .set_index (set_index),
        .bank_we   (bank_we),
        .wline     (wline),
        .way_line  (way_line)
    );

    store_merge store_merge_i (
        .hit_store (hit_store),
        .refill    (refill),
        .way       (hit_way),
        .cur_req   (cur_req),
        .ret_data  (ret_data),
        .cur_line  (sel_line),
        .bank_we   (bank_we),
        .wline     (wline)
    );

endmodule

`default_nettype wire

//--- verification/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int NUM_REQ    = 400;
    localparam int CLK_PERIOD = 10;

    logic     clk;
    logic     reset;
    logic     req_valid;
    cpu_req_t req;
    logic     addr_ok;
    logic     data_ok;
    word_t    rdata;
    logic     rd_req;
    addr_t    rd_addr;
    logic     rd_rdy;
    logic     ret_valid;
    line_t    ret_data;
    logic     wr_req;
    addr_t    wr_addr;
    line_t    wr_data;
    logic     wr_rdy;

    // latest value of every word and the memory behind the cache
    word_t arch [addr_t];
    word_t mem_img [addr_t];

    // model of the tag side
    tag_t m_tag [NUM_WAYS][NUM_SETS];
    bit   m_valid [NUM_WAYS][NUM_SETS];
    bit   m_dirty [NUM_WAYS][NUM_SETS];
    bit   m_victim [NUM_SETS];

    // three tags on four sets so lines collide
    tag_t   tags [3] = '{20'h00012, 20'h0abcd, 20'hf0f01};
    index_t sets [4] = '{8'h03, 8'h47, 8'h80, 8'hff};

    dcache_top dcache_top_i (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ///////////////////////////////////////////////////////////////////////
    // helpers
    ///////////////////////////////////////////////////////////////////////
    task automatic check_val(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %0h, expected %0h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // initial memory contents as a hash of the full address
    function automatic word_t pattern(addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'hc3a5_0f1e;
    endfunction

    function automatic word_t read_word(addr_t a, bit from_arch);
        if (from_arch && arch.exists(a)) begin
            return arch[a];
        end else if (!from_arch && mem_img.exists(a)) begin
            return mem_img[a];
        end
        return pattern(a);
    endfunction

    function automatic line_t read_line(addr_t base, bit from_arch);
        line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            l[i*32 +: 32] = read_word(base + addr_t'(i * 4), from_arch);
        end
        return l;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // memory responder
    ///////////////////////////////////////////////////////////////////////
    initial begin : mem_responder
        bit          rd_take;
        bit          wr_take;
        bit          pending;
        int unsigned wait_cnt;
        addr_t       rd_line;
        addr_t       wr_line;
        line_t       wr_line_data;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        pending   = 1'b0;
        wait_cnt  = 0;
        forever begin
            @(negedge clk);
            rd_take = rd_req && rd_rdy;
            wr_take = wr_req && wr_rdy;
            if (rd_take) begin
                rd_line = rd_addr;
            end
            if (wr_take) begin
                wr_line      = wr_addr;
                wr_line_data = wr_data;
            end
            @(posedge clk);
            #1;
            if (wr_take) begin
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    mem_img[wr_line + addr_t'(i * 4)] = wr_line_data[i*32 +: 32];
                end
            end
            ret_valid = 1'b0;
            if (rd_take) begin
                pending  = 1'b1;
                wait_cnt = $urandom_range(0, 4);
            end
            if (pending) begin
                if (wait_cnt == 0) begin
                    ret_valid = 1'b1;
                    ret_data  = read_line(rd_line, 1'b0);
                    pending   = 1'b0;
                end else begin
                    wait_cnt--;
                end
            end
            rd_rdy = ($urandom_range(0, 2) == 0);
            wr_rdy = ($urandom_range(0, 2) == 0);
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // one request predicted by the model and checked cycle by cycle
    ///////////////////////////////////////////////////////////////////////
    task automatic run_request(input cpu_req_t r);
        index_t      s;
        bit          exp_hit;
        bit          hw;
        bit          vw;
        bit          vdirty;
        addr_t       word_addr;
        addr_t       vline;
        word_t       cur;
        word_t       got_rdata;
        int          cycles;
        int unsigned gap;
        bit          seen_wr;
        bit          seen_rd;
        bit          done;
        s       = r.index;
        exp_hit = 1'b0;
        hw      = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[w][s] && m_tag[w][s] == r.tag) begin
                exp_hit = 1'b1;
                hw      = 1'(w);
            end
        end
        // invalid way first, then the victim bit
        if (!m_valid[0][s]) begin
            vw = 1'b0;
        end else if (!m_valid[1][s]) begin
            vw = 1'b1;
        end else begin
            vw = m_victim[s];
        end
        vdirty    = m_valid[vw][s] && m_dirty[vw][s];
        vline     = {m_tag[vw][s], s, 4'h0};
        word_addr = {r.tag, r.index, r.offset[3:2], 2'b00};

        gap = $urandom_range(0, 2);
        repeat (gap + 1) @(posedge clk);
        #1;
        req_valid = 1'b1;
        req       = r;
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        req       = cpu_req_t'({$urandom, $urandom, 5'($urandom)});

        cycles  = 0;
        seen_wr = 1'b0;
        seen_rd = 1'b0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            // busy until the request completes
            check_val("addr_ok", line_t'(addr_ok), line_t'(0));
            if (wr_req) begin
                seen_wr = 1'b1;
                check_val("wr_addr", line_t'(wr_addr), line_t'(vline));
                check_val("wr_data", wr_data, read_line(vline, 1'b1));
            end
            if (rd_req) begin
                seen_rd = 1'b1;
                check_val("rd_addr", line_t'(rd_addr), line_t'({r.tag, r.index, 4'h0}));
                // writeback must already be done
                check_val("wr_req before rd_req", line_t'(seen_wr), line_t'(vdirty));
            end
            if (data_ok) begin
                done      = 1'b1;
                got_rdata = rdata;
                if (!exp_hit) begin
                    // a miss completes with the memory return
                    check_val("ret_valid", line_t'(ret_valid), line_t'(1));
                end
            end
        end

        if (exp_hit) begin
            check_val("data_ok latency", line_t'(cycles), line_t'(1));
        end
        check_val("wr_req seen", line_t'(seen_wr), line_t'(!exp_hit && vdirty));
        check_val("rd_req seen", line_t'(seen_rd), line_t'(!exp_hit));
        if (!r.op) begin
            check_val("rdata", line_t'(got_rdata), line_t'(read_word(word_addr, 1'b1)));
        end

        if (r.op) begin
            cur = read_word(word_addr, 1'b1);
            for (int b = 0; b < 4; b++) begin
                if (r.wstrb[b]) begin
                    cur[b*8 +: 8] = r.wdata[b*8 +: 8];
                end
            end
            arch[word_addr] = cur;
        end
        if (exp_hit) begin
            if (r.op) begin
                m_dirty[hw][s] = 1'b1;
            end
        end else begin
            m_tag[vw][s]   = r.tag;
            m_valid[vw][s] = 1'b1;
            m_dirty[vw][s] = r.op;
            m_victim[s]    = ~m_victim[s];
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // main sequence
    ///////////////////////////////////////////////////////////////////////
    initial begin : main_seq
        cpu_req_t r;
        void'($urandom(32'hb675_647a));
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_val("addr_ok", line_t'(addr_ok), line_t'(1));
        check_val("data_ok", line_t'(data_ok), line_t'(0));
        check_val("rd_req", line_t'(rd_req), line_t'(0));
        check_val("wr_req", line_t'(wr_req), line_t'(0));

        for (int n = 0; n < NUM_REQ; n++) begin
            r.op     = 1'($urandom_range(0, 1));
            r.tag    = tags[$urandom_range(0, 2)];
            r.index  = sets[$urandom_range(0, 3)];
            r.offset = {2'($urandom_range(0, 3)), 2'b00};
            r.wstrb  = 4'($urandom_range(0, 15));
            r.wdata  = $urandom;
            run_request(r);
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin : watchdog
        #(NUM_REQ * 200 * CLK_PERIOD);
        $display("timeout: requests stopped completing, controller in state %s",
                 dcache_top_i.cache_ctrl_i.state.name());
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- project.f
design/dcache_pkg.sv
design/store_merge.sv
design/data_store.sv
design/tag_store.sv
design/cache_ctrl.sv
design/dcache_top.sv
verification/tb_dcache.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -j 0 \
    -f project.f --top-module tb_dcache -o tb_dcache

out=$(./obj_dir/tb_dcache || true)
echo "$out"
if echo "$out" | grep -q "Done: no errors"; then
    exit 0
else
    exit 1
fi
